//--- src/lz77_pkg.sv
//--------------------------------------
// lz77 shared types
// byte, length and distance widths plus
// the controller state encoding
//--------------------------------------

`default_nettype none

package lz77_pkg;

  // ------------------------------------
  // field widths
  // ------------------------------------
  localparam int LEN_W = 4;  // lengths up to 8
  localparam int DST_W = 5;  // distances up to 16

  // ------------------------------------
  // data and state types
  // ------------------------------------
  typedef logic [7:0] byte_t;

  // controller sequence
  // fill lookahead, walk window, hand out token, slide
  typedef enum logic [1:0] {
    FILL   = 2'd0,
    SEARCH = 2'd1,
    EMIT   = 2'd2,
    SHIFT  = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/lz77_detect_one.sv
//--------------------------------------
// lz77 nearest match detector
// lowest set flag gives the distance
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_detect_one import lz77_pkg::*; #(
  parameter int WIN_SIZE = 16
) (
  input  wire  [WIN_SIZE-1:0] flags_i,
  output logic [DST_W-1:0]    best_dst_o,
  output logic                any_o
);

  // chain[i] holds the answer for flags i and above
  logic [DST_W-1:0] dst_chain [WIN_SIZE+1];

  assign dst_chain[WIN_SIZE] = '0;  // nothing set

  // fixed priority, lower index wins
  for (genvar i = 0; i < WIN_SIZE; i++) begin : g_scan
    assign dst_chain[i] = flags_i[i] ? DST_W'(i + 1) : dst_chain[i+1];
  end

  assign best_dst_o = dst_chain[0];
  assign any_o      = |flags_i;

endmodule

`default_nettype wire

//--- src/lz77_match.sv
//--------------------------------------
// lz77 window matcher
// one flag per distance, pruned by one
// lookahead byte per cycle
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_match import lz77_pkg::*; #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        srch_start_i,
  input  wire byte_t [WIN_SIZE-1:0]  hist_i,
  input  wire byte_t [LEN_MAX-1:0]   look_i,
  input  wire        [DST_W-1:0]     hist_cnt_i,
  input  wire        [LEN_W-1:0]     look_cnt_i,
  output logic       [WIN_SIZE-1:0]  flags_o,
  output logic       [DST_W-1:0]     best_dst_o,
  output logic       [LEN_W-1:0]     step_o,
  output logic                       alive_o,
  output logic                       srch_end_o
);

  logic                       active_q;
  logic [WIN_SIZE-1:0]        flags_init;
  logic [WIN_SIZE-1:0]        flags_nxt;
  byte_t [WIN_SIZE-1:0]       hist_sh;    // hist_sh[i] = hist_i[i - step]
  byte_t [LEN_MAX-1:0]        look_sh;
  logic [LEN_W-1:0]           step_nxt;
  logic [LEN_W-1:0]           lim;

  // ------------------------------------
  // compare step
  // ------------------------------------
  assign lim      = (look_cnt_i < LEN_W'(LEN_MAX)) ? look_cnt_i : LEN_W'(LEN_MAX);
  assign step_nxt = step_o + LEN_W'(1);
  assign hist_sh  = hist_i << ($bits(byte_t) * step_o);
  assign look_sh  = look_i >> ($bits(byte_t) * step_o);

  always_comb begin
    for (int i = 0; i < WIN_SIZE; i++) begin
      flags_init[i] = (i < int'(hist_cnt_i));  // only filled window slots
      // distance must exceed step so the match stays out of the lookahead
      flags_nxt[i]  = flags_o[i] && (int'(step_o) <= i) && (hist_sh[i] == look_sh[0]);
    end
  end

  // ------------------------------------
  // flags and step counter
  // ------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flags_o    <= '0;
      step_o     <= '0;
      active_q   <= 1'b0;
      srch_end_o <= 1'b0;
    end else begin
      srch_end_o <= 1'b0;
      if (srch_start_i) begin
        flags_o  <= flags_init;
        step_o   <= '0;
        active_q <= 1'b1;
      end else if (active_q) begin
        flags_o <= flags_nxt;
        step_o  <= step_nxt;
        if (!(|flags_nxt) || (step_nxt >= lim)) begin  // dead or at length limit
          active_q   <= 1'b0;
          srch_end_o <= 1'b1;
        end
      end
    end
  end

  lz77_detect_one #(
    .WIN_SIZE (WIN_SIZE)
  ) u_detect_one (
    .flags_i    (flags_o),
    .best_dst_o (best_dst_o),
    .any_o      (alive_o)
  );

  // window and lookahead counts hold still while flags are pruned
  a_inputs_stable: assert property (@(posedge clk) disable iff (!rstn)
    active_q && !srch_start_i |=> $stable(hist_cnt_i) && $stable(look_cnt_i));

endmodule

`default_nettype wire

//--- src/lz77_buffer.sv
//--------------------------------------
// lz77 byte storage
// history window plus lookahead, filled
// one byte at a time, slid per token
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_buffer import lz77_pkg::*; #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        push_i,
  input  wire byte_t                 in_data_i,
  input  wire                        in_last_i,
  input  wire        [LEN_W-1:0]     shift_len_i,
  input  wire                        shift_i,
  output byte_t      [WIN_SIZE-1:0]  hist_o,
  output byte_t      [LEN_MAX-1:0]   look_o,
  output logic       [DST_W-1:0]     hist_cnt_o,
  output logic       [LEN_W-1:0]     look_cnt_o,
  output logic                       look_last_o
);

  byte_t [WIN_SIZE-1:0]          hist_q;   // nearest byte at index 0
  byte_t [LEN_MAX-1:0]           look_q;   // oldest byte at index 0
  byte_t [LEN_MAX-1:0]           look_rev;
  byte_t [WIN_SIZE+LEN_MAX-1:0]  cat_w;
  byte_t [WIN_SIZE+LEN_MAX-1:0]  cat_sh;
  byte_t [LEN_MAX-1:0]           look_shf;
  logic  [DST_W:0]               hist_sum;
  logic  [DST_W-1:0]             hist_sat;

  // ------------------------------------
  // shift datapath
  // ------------------------------------
  always_comb begin
    for (int j = 0; j < LEN_MAX; j++) begin
      look_rev[j] = look_q[LEN_MAX-1-j];
    end
  end

  // consumed bytes land at the near end of the window, newest first
  assign cat_w    = {hist_q, look_rev};
  assign cat_sh   = cat_w >> ($bits(byte_t) * (LEN_MAX - int'(shift_len_i)));
  assign look_shf = look_q >> ($bits(byte_t) * shift_len_i);

  assign hist_sum = {1'b0, hist_cnt_o} + (DST_W+1)'(shift_len_i);
  assign hist_sat = (hist_sum > (DST_W+1)'(WIN_SIZE)) ? DST_W'(WIN_SIZE) : hist_sum[DST_W-1:0];

  // ------------------------------------
  // byte storage
  // ------------------------------------
  always_ff @(posedge clk) begin
    if (push_i) begin
      for (int j = 0; j < LEN_MAX; j++) begin
        if (int'(look_cnt_o) == j) look_q[j] <= in_data_i;  // append at tail
      end
    end else if (shift_i) begin
      hist_q <= cat_sh[WIN_SIZE-1:0];
      look_q <= look_shf;
    end
  end

  // ------------------------------------
  // counts and frame end
  // ------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hist_cnt_o  <= '0;
      look_cnt_o  <= '0;
      look_last_o <= 1'b0;
    end else if (push_i) begin
      look_cnt_o <= look_cnt_o + LEN_W'(1);
      if (in_last_i) look_last_o <= 1'b1;
    end else if (shift_i) begin
      look_cnt_o <= look_cnt_o - shift_len_i;
      if (look_last_o && (look_cnt_o == shift_len_i)) begin
        // frame fully consumed, next frame starts with an empty window
        hist_cnt_o  <= '0;
        look_last_o <= 1'b0;
      end else begin
        hist_cnt_o <= hist_sat;
      end
    end
  end

  assign hist_o = hist_q;
  assign look_o = look_q;

  // controller must stop filling once the lookahead is full
  a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
    push_i |-> (look_cnt_o < LEN_W'(LEN_MAX)));

endmodule

`default_nettype wire

//--- src/lz77_ctrl.sv
//--------------------------------------
// lz77 frame controller
// sequences fill, search, emit, shift
// and holds the outgoing token
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_ctrl import lz77_pkg::*; #(
  parameter int LEN_MAX = 8,
  parameter int LEN_MIN = 3
) (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    in_valid_i,
  input  wire                    in_last_i,
  input  wire                    tok_ready_i,
  input  wire        [LEN_W-1:0] look_cnt_i,
  input  wire                    look_last_i,
  input  wire byte_t             look_head_i,
  input  wire        [DST_W-1:0] best_dst_i,
  input  wire                    any_i,
  input  wire        [LEN_W-1:0] step_i,
  input  wire                    srch_end_i,
  output logic                   in_ready_o,
  output logic                   push_o,
  output logic                   shift_o,
  output logic       [LEN_W-1:0] shift_len_o,
  output logic                   srch_start_o,
  output logic                   tok_valid_o,
  output logic                   tok_lit_o,
  output byte_t                  tok_data_o,
  output logic       [LEN_W-1:0] tok_len_o,
  output logic       [DST_W-1:0] tok_dst_o,
  output logic                   tok_last_o,
  output logic                   done_o
);

  ctrl_state_e      state_q, state_d;
  logic [LEN_W-1:0] best_len_q;
  logic [DST_W-1:0] best_dst_q;
  logic             rec_hit;
  logic [LEN_W-1:0] cur_len;
  logic [DST_W-1:0] cur_dst;
  logic             lit_sel;
  logic [LEN_W-1:0] tok_len_d;

  // ------------------------------------
  // best match tracking
  // ------------------------------------
  // step 0 and the start cycle carry no fresh compare result
  assign rec_hit   = (state_q == SEARCH) && !srch_start_o && any_i && (step_i != '0);
  assign cur_len   = rec_hit ? step_i : best_len_q;
  assign cur_dst   = rec_hit ? best_dst_i : best_dst_q;
  assign lit_sel   = cur_len < LEN_W'(LEN_MIN);
  assign tok_len_d = lit_sel ? LEN_W'(1) : cur_len;

  // ------------------------------------
  // fsm
  // ------------------------------------
  assign in_ready_o  = (state_q == FILL);
  assign push_o      = in_valid_i && in_ready_o;
  assign tok_valid_o = (state_q == EMIT);
  assign shift_o     = (state_q == SHIFT);
  assign shift_len_o = tok_len_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FILL: begin
        if (push_o && (in_last_i || (look_cnt_i == LEN_W'(LEN_MAX - 1)))) state_d = SEARCH;
      end
      SEARCH: if (srch_end_i) state_d = EMIT;
      EMIT:   if (tok_ready_i) state_d = SHIFT;
      SHIFT: begin
        // leftover bytes of a closed frame need no more input
        if (look_last_i && (look_cnt_i != tok_len_o)) state_d = SEARCH;
        else state_d = FILL;
      end
      default: state_d = FILL;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q      <= FILL;
      srch_start_o <= 1'b0;
      done_o       <= 1'b0;
      best_len_q   <= '0;
      best_dst_q   <= '0;
    end else begin
      state_q      <= state_d;
      srch_start_o <= (state_d == SEARCH) && (state_q != SEARCH);
      done_o       <= (state_q == EMIT) && tok_ready_i && tok_last_o;
      if (srch_start_o) begin
        best_len_q <= '0;
        best_dst_q <= '0;
      end else if (rec_hit) begin
        best_len_q <= step_i;  // longest so far
        best_dst_q <= best_dst_i;
      end
    end
  end

  // ------------------------------------
  // token register
  // ------------------------------------
  always_ff @(posedge clk) begin
    if ((state_q == SEARCH) && srch_end_i) begin
      tok_lit_o  <= lit_sel;
      tok_data_o <= look_head_i;
      tok_len_o  <= tok_len_d;
      tok_dst_o  <= lit_sel ? '0 : cur_dst;
      tok_last_o <= look_last_i && (look_cnt_i == tok_len_d);  // covers final byte
    end
  end

  a_tok_stable: assert property (@(posedge clk) disable iff (!rstn)
    tok_valid_o && !tok_ready_i |=> tok_valid_o && $stable(tok_lit_o) &&
      $stable(tok_data_o) && $stable(tok_len_o) && $stable(tok_dst_o) && $stable(tok_last_o));

endmodule

`default_nettype wire

//--- src/lz77_top.sv
//--------------------------------------
// lz77 compressor top
// byte stream in, literal or match
// tokens out, one token at a time
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_top import lz77_pkg::*; #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8,
  parameter int LEN_MIN  = 3
) (
  input  wire                    clk,
  input  wire                    rstn,
  // byte input
  input  wire                    in_valid_i,
  input  wire byte_t             in_data_i,
  input  wire                    in_last_i,
  output logic                   in_ready_o,
  // token output
  output logic                   tok_valid_o,
  output logic                   tok_lit_o,
  output byte_t                  tok_data_o,
  output logic       [LEN_W-1:0] tok_len_o,
  output logic       [DST_W-1:0] tok_dst_o,
  output logic                   tok_last_o,
  input  wire                    tok_ready_i,
  output logic                   done_o
);

  // buffer to matcher and controller
  byte_t [WIN_SIZE-1:0] hist;
  byte_t [LEN_MAX-1:0]  look;
  logic  [DST_W-1:0]    hist_cnt;
  logic  [LEN_W-1:0]    look_cnt;
  logic                 look_last;

  // controller to buffer and matcher
  logic                 push;
  logic                 shift;
  logic  [LEN_W-1:0]    shift_len;
  logic                 srch_start;

  // matcher to controller
  logic  [DST_W-1:0]    best_dst;
  logic  [LEN_W-1:0]    step;
  logic                 alive;
  logic                 srch_end;

  lz77_buffer #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) u_buffer (
    .clk         (clk),
    .rstn        (rstn),
    .push_i      (push),
    .in_data_i   (in_data_i),
    .in_last_i   (in_last_i),
    .shift_len_i (shift_len),
    .shift_i     (shift),
    .hist_o      (hist),
    .look_o      (look),
    .hist_cnt_o  (hist_cnt),
    .look_cnt_o  (look_cnt),
    .look_last_o (look_last)
  );

  lz77_match #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) u_match (
    .clk          (clk),
    .rstn         (rstn),
    .srch_start_i (srch_start),
    .hist_i       (hist),
    .look_i       (look),
    .hist_cnt_i   (hist_cnt),
    .look_cnt_i   (look_cnt),
    .flags_o      (),
    .best_dst_o   (best_dst),
    .step_o       (step),
    .alive_o      (alive),
    .srch_end_o   (srch_end)
  );

  lz77_ctrl #(
    .LEN_MAX (LEN_MAX),
    .LEN_MIN (LEN_MIN)
  ) u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .in_valid_i   (in_valid_i),
    .in_last_i    (in_last_i),
    .tok_ready_i  (tok_ready_i),
    .look_cnt_i   (look_cnt),
    .look_last_i  (look_last),
    .look_head_i  (look[0]),  // current byte
    .best_dst_i   (best_dst),
    .any_i        (alive),
    .step_i       (step),
    .srch_end_i   (srch_end),
    .in_ready_o   (in_ready_o),
    .push_o       (push),
    .shift_o      (shift),
    .shift_len_o  (shift_len),
    .srch_start_o (srch_start),
    .tok_valid_o  (tok_valid_o),
    .tok_lit_o    (tok_lit_o),
    .tok_data_o   (tok_data_o),
    .tok_len_o    (tok_len_o),
    .tok_dst_o    (tok_dst_o),
    .tok_last_o   (tok_last_o),
    .done_o       (done_o)
  );

endmodule

`default_nettype wire

//--- dv/lz77_checker.sv
//--------------------------------------
// lz77 token checker
// reference token model, field compare
// and decode back to the input bytes
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_checker import lz77_pkg::*; #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8,
  parameter int LEN_MIN  = 3
) (
  input  wire              clk,
  input  wire              rstn,
  input  wire              in_valid_i,
  input  wire              in_ready_i,
  input  wire byte_t       in_data_i,
  input  wire              in_last_i,
  input  wire              tok_valid_i,
  input  wire              tok_ready_i,
  input  wire              tok_lit_i,
  input  wire byte_t       tok_data_i,
  input  wire [LEN_W-1:0]  tok_len_i,
  input  wire [DST_W-1:0]  tok_dst_i,
  input  wire              tok_last_i,
  input  wire              done_i,
  output int               mismatch_cnt_o,
  output int               fail_cnt_o,
  output int               frame_cnt_o,
  output int               match_cnt_o
);

  localparam int MAX_FRAME = 256;

  byte_t src_q [MAX_FRAME];  // accepted input bytes of the open frame
  byte_t dec_q [MAX_FRAME];  // bytes rebuilt from tokens
  int    rx_cnt;
  int    dec_cnt;            // also the current position
  int    tok_cnt;
  logic  ended;
  logic  done_exp;

  initial begin
    mismatch_cnt_o = 0;
    fail_cnt_o     = 0;
    frame_cnt_o    = 0;
    match_cnt_o    = 0;
    rx_cnt         = 0;
    dec_cnt        = 0;
    tok_cnt        = 0;
    ended          = 1'b0;
    done_exp       = 1'b0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatch_cnt_o++;
    $display("Mismatch %s: got %h, expected %h (token %0d)", name, got, exp, tok_cnt);
  endtask

  task automatic report_fail(input string what);
    fail_cnt_o++;
    $display("Error: %s (token %0d, time %0t)", what, tok_cnt, $time);
  endtask

  // ------------------------------------
  // reference model
  // ------------------------------------
  // longest non-overlapping match, nearest distance on a tie
  function automatic void find_match(input int p, output int len, output int dst);
    int lmax;
    int dmax;
    int l;
    lmax = (rx_cnt - p < LEN_MAX) ? rx_cnt - p : LEN_MAX;
    dmax = (p < WIN_SIZE) ? p : WIN_SIZE;
    len  = 0;
    dst  = 0;
    for (int d = 1; d <= dmax; d++) begin
      l = 0;
      while (l < lmax && l < d && src_q[p+l] == src_q[p+l-d]) l++;
      if (l > len) begin
        len = l;
        dst = d;
      end
    end
  endfunction

  task automatic take_byte();
    if (ended) begin
      report_fail("input byte accepted before the previous frame was fully tokenized");
      rx_cnt  = 0;
      dec_cnt = 0;
      ended   = 1'b0;
    end
    if (rx_cnt < MAX_FRAME) begin
      src_q[rx_cnt] = in_data_i;
      rx_cnt++;
    end else begin
      report_fail("frame longer than the checker buffer");
    end
    if (in_last_i) ended = 1'b1;
  endtask

  task automatic push_decoded(input byte_t b);
    if (dec_cnt >= rx_cnt) begin
      report_fail("decoded output runs past the input frame");
    end else if (b !== src_q[dec_cnt]) begin
      report_mismatch("decoded byte", 32'(b), 32'(src_q[dec_cnt]));
    end
    if (dec_cnt < MAX_FRAME) begin
      dec_q[dec_cnt] = b;
      dec_cnt++;
    end
  endtask

  task automatic check_token();
    int   p;
    int   m_len;
    int   m_dst;
    int   e_len;
    int   e_dst;
    int   src;
    logic e_lit;
    logic e_last;
    p = dec_cnt;
    if (p >= rx_cnt) begin
      report_fail("token arrived with no unconsumed input byte");
      return;
    end
    if (!ended && (rx_cnt - p < LEN_MAX)) report_fail("token sent before the lookahead was full");
    find_match(p, m_len, m_dst);
    e_lit  = (m_len < LEN_MIN);
    e_len  = e_lit ? 1 : m_len;
    e_dst  = e_lit ? 0 : m_dst;
    e_last = ended && (p + e_len == rx_cnt);  // token covers the final byte
    if (tok_lit_i !== e_lit) report_mismatch("tok_lit_o", 32'(tok_lit_i), 32'(e_lit));
    if (tok_len_i !== LEN_W'(e_len)) report_mismatch("tok_len_o", 32'(tok_len_i), e_len);
    if (tok_dst_i !== DST_W'(e_dst)) report_mismatch("tok_dst_o", 32'(tok_dst_i), e_dst);
    if (tok_last_i !== e_last) report_mismatch("tok_last_o", 32'(tok_last_i), 32'(e_last));
    if (e_lit && (tok_data_i !== src_q[p])) begin
      report_mismatch("tok_data_o", 32'(tok_data_i), 32'(src_q[p]));
    end
    // ------------------------------------
    // rebuild from the DUT's own fields
    // ------------------------------------
    if (tok_lit_i) begin
      push_decoded(tok_data_i);
    end else if (tok_len_i == '0) begin
      report_fail("match token with zero length");
    end else begin
      for (int k = 0; k < int'(tok_len_i); k++) begin
        src = dec_cnt - int'(tok_dst_i);
        if (tok_dst_i == '0 || src < 0) begin
          report_fail("match distance reaches outside the current frame");
          break;
        end
        push_decoded(dec_q[src]);
      end
    end
  endtask

  task automatic close_frame();
    if (!ended) report_fail("last token flagged before the frame's last byte arrived");
    else if (dec_cnt != rx_cnt) report_fail("last token does not end at the final byte");
    frame_cnt_o++;
    rx_cnt  = 0;
    dec_cnt = 0;  // window starts empty for the next frame
    ended   = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rstn) begin
      if (done_i !== done_exp) report_mismatch("done_o", 32'(done_i), 32'(done_exp));
      done_exp = 1'b0;
      if (in_valid_i && in_ready_i) take_byte();
      if (tok_valid_i && tok_ready_i) begin
        check_token();
        tok_cnt++;
        if (!tok_lit_i) match_cnt_o++;
        if (tok_last_i) begin
          close_frame();
          done_exp = 1'b1;  // pulse due one cycle later
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/lz77_tb.sv
//--------------------------------------
// lz77 compressor testbench
// table driven frames, random output
// stalls and a run watchdog
//--------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lz77_tb import lz77_pkg::*; ();

  localparam int          WIN_SIZE   = 16;
  localparam int          LEN_MAX    = 8;
  localparam int          LEN_MIN    = 3;
  localparam int          CLK_PERIOD = 8;
  localparam int          N_ROWS     = 9;
  localparam int          MAX_FRAME  = 64;
  localparam logic [31:0] SEED       = 32'hb29e;

  // pattern kinds
  localparam int PAT_DISTINCT = 0;  // aux is the first byte
  localparam int PAT_PHRASE   = 1;  // aux is the phrase length
  localparam int PAT_RUN      = 2;  // aux is the repeated byte
  localparam int PAT_RANDOM   = 3;
  // match tokens expected in a frame
  localparam int EXP_NONE = 0;
  localparam int EXP_SOME = 1;
  localparam int EXP_ANY  = 2;

  logic             clk = 1'b0;
  logic             rstn;
  logic             in_valid;
  byte_t            in_data;
  logic             in_last;
  logic             in_ready;
  logic             tok_valid;
  logic             tok_lit;
  byte_t            tok_data;
  logic [LEN_W-1:0] tok_len;
  logic [DST_W-1:0] tok_dst;
  logic             tok_last;
  logic             tok_ready;
  logic             done;

  int    row_kind  [N_ROWS];
  int    row_len   [N_ROWS];
  int    row_aux   [N_ROWS];
  int    row_stall [N_ROWS];  // percent of cycles with tok_ready low
  int    row_exp   [N_ROWS];
  byte_t frame_buf [MAX_FRAME];

  logic [31:0] data_seed;
  logic [31:0] stall_seed;
  int          stall_pct;
  int          wd_cycles;
  int          tb_err;
  int          mismatch_cnt;
  int          fail_cnt;
  int          frame_cnt;
  int          match_cnt;

  lz77_top #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX),
    .LEN_MIN  (LEN_MIN)
  ) DUT (
    .clk         (clk),
    .rstn        (rstn),
    .in_valid_i  (in_valid),
    .in_data_i   (in_data),
    .in_last_i   (in_last),
    .in_ready_o  (in_ready),
    .tok_valid_o (tok_valid),
    .tok_lit_o   (tok_lit),
    .tok_data_o  (tok_data),
    .tok_len_o   (tok_len),
    .tok_dst_o   (tok_dst),
    .tok_last_o  (tok_last),
    .tok_ready_i (tok_ready),
    .done_o      (done)
  );

  lz77_checker #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX),
    .LEN_MIN  (LEN_MIN)
  ) u_checker (
    .clk            (clk),
    .rstn           (rstn),
    .in_valid_i     (in_valid),
    .in_ready_i     (in_ready),
    .in_data_i      (in_data),
    .in_last_i      (in_last),
    .tok_valid_i    (tok_valid),
    .tok_ready_i    (tok_ready),
    .tok_lit_i      (tok_lit),
    .tok_data_i     (tok_data),
    .tok_len_i      (tok_len),
    .tok_dst_i      (tok_dst),
    .tok_last_i     (tok_last),
    .done_i         (done),
    .mismatch_cnt_o (mismatch_cnt),
    .fail_cnt_o     (fail_cnt),
    .frame_cnt_o    (frame_cnt),
    .match_cnt_o    (match_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // output back-pressure from its own random stream
  always @(negedge clk) begin
    stall_seed = lcg_next(stall_seed);
    tok_ready  = (int'(stall_seed[31:16]) % 100) >= stall_pct;
  end

  task automatic set_row(input int r, input int kind, input int len, input int aux,
                         input int stall, input int exp);
    row_kind[r]  = kind;
    row_len[r]   = len;
    row_aux[r]   = aux;
    row_stall[r] = stall;
    row_exp[r]   = exp;
  endtask

  task automatic build_frame(input int kind, input int len, input int aux);
    for (int i = 0; i < len; i++) begin
      case (kind)
        PAT_DISTINCT: frame_buf[i] = byte_t'(aux + i);
        PAT_PHRASE:   frame_buf[i] = byte_t'('h41 + (i % aux));
        PAT_RUN:      frame_buf[i] = byte_t'(aux);
        default: begin
          data_seed    = lcg_next(data_seed);
          frame_buf[i] = byte_t'('h30 + int'(data_seed[31:30]));  // small alphabet
        end
      endcase
    end
  endtask

  task automatic send_frame(input int len);
    int   idx;
    logic accepted;
    idx = 0;
    @(negedge clk);
    while (idx < len) begin
      in_valid = 1'b1;
      in_data  = frame_buf[idx];
      in_last  = (idx == len - 1);
      accepted = in_ready;  // ready only moves on rising edges
      @(negedge clk);
      if (accepted) idx++;
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic check_row(input int r, input int n_match);
    if (row_exp[r] == EXP_NONE && n_match != 0) begin
      tb_err++;
      $display("row %0d: %0d match tokens where only literals were expected", r, n_match);
    end else if (row_exp[r] == EXP_SOME && n_match == 0) begin
      tb_err++;
      $display("row %0d: no match tokens for a repeating pattern", r);
    end
  endtask

  initial begin
    int total_bytes;
    int n_match;
    rstn       = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    in_last    = 1'b0;
    tok_ready  = 1'b1;
    stall_pct  = 0;
    tb_err     = 0;
    data_seed  = SEED;
    stall_seed = SEED;

    //         kind          len aux    stall exp
    set_row(0, PAT_DISTINCT, 20, 'h20,  0,    EXP_NONE);
    set_row(1, PAT_PHRASE,   30, 5,     0,    EXP_SOME);
    set_row(2, PAT_PHRASE,   40, 8,     25,   EXP_SOME);
    set_row(3, PAT_DISTINCT, 16, 'h41,  0,    EXP_NONE);  // reuses the row 2 phrase bytes
    set_row(4, PAT_RUN,      5,  'h61,  0,    EXP_NONE);  // too short to match
    set_row(5, PAT_RUN,      24, 'h7a,  30,   EXP_SOME);
    set_row(6, PAT_RANDOM,   48, 0,     50,   EXP_ANY);
    set_row(7, PAT_RANDOM,   33, 0,     10,   EXP_ANY);
    set_row(8, PAT_DISTINCT, 1,  'h55,  40,   EXP_NONE);

    total_bytes = 0;
    for (int r = 0; r < N_ROWS; r++) total_bytes += row_len[r];
    wd_cycles = total_bytes * (LEN_MAX + 4) + 300;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    for (int r = 0; r < N_ROWS; r++) begin
      build_frame(row_kind[r], row_len[r], row_aux[r]);
      @(posedge clk);
      stall_pct = row_stall[r];
      n_match   = match_cnt;
      send_frame(row_len[r]);
      while (!done) @(negedge clk);
      check_row(r, match_cnt - n_match);
    end

    repeat (4) @(negedge clk);
    if (frame_cnt != N_ROWS) begin
      tb_err++;
      $display("frame count wrong: %0d frames closed, %0d sent", frame_cnt, N_ROWS);
    end
    $display("errors: mismatch %0d, other %0d, testbench %0d", mismatch_cnt, fail_cnt, tb_err);
    if (mismatch_cnt + fail_cnt + tb_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // ------------------------------------
  // watchdog
  // ------------------------------------
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", wd_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- lz77.f
src/lz77_pkg.sv
src/lz77_detect_one.sv
src/lz77_match.sv
src/lz77_buffer.sv
src/lz77_ctrl.sv
src/lz77_top.sv
dv/lz77_checker.sv
dv/lz77_tb.sv

//--- Makefile
TOP := lz77_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f lz77.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f lz77.f

clean:
	rm -rf obj_dir
